//--- Makefile
BUILD := obj_dir

sim:
	verilator --binary --timing --top-module tb_rv_core -Mdir $(BUILD) -f rv_core.f
	./$(BUILD)/Vtb_rv_core

clean:
	rm -rf $(BUILD)

.PHONY: sim clean

//--- dv/rv_core_stimulus.hex
// Words 0 to 191: program, one instruction per line, data area at 0x200
// Words 192 onward: expected stores as address, data, strobes; all-ones address ends it
@00000000
20000513 // addi x10, x0, 0x200
06400093 // addi x1, x0, 100
FF900113 // addi x2, x0, -7
002081B3 // add x3, x1, x2
00352023
40208233 // sub x4, x1, x2
00452223
001122B3 // slt x5, x2, x1
00552423
00113333 // sltu x6, x2, x1
00652623
0020C3B3 // xor x7, x1, x2
00752823
0020E433 // or x8, x1, x2
0F047493 // andi x9, x8, 0xf0
00952A23
ABCDE5B7 // lui x11, 0xabcde
00B52C23
00001617 // auipc x12, 1
00C52E23
876546B7 // lui x13, 0x87654
32168693 // addi x13, x13, 0x321
4006D713 // srai x14, x13, 0
02E52023
0036D713 // srli x14, x13, 3
02E52223
4046D713 // srai x14, x13, 4
02E52423
00D69713 // slli x14, x13, 13
02E52623
41F6D713 // srai x14, x13, 31
02E52823
02D50AA3 // sb x13, 0x35(x10)
02750BA3 // sb x7, 0x37(x10)
02B51C23 // sh x11, 0x38(x10)
02D51D23 // sh x13, 0x3a(x10)
03750803 // lb x16, 0x37(x10)
03754A03 // lbu x20, 0x37(x10)
01480833 // add x16, x16, x20
03052E23
03851803 // lh x16, 0x38(x10)
03855A03 // lhu x20, 0x38(x10)
01480833
05052023
00208463 // beq x1, x2, +8 not taken
00188893 // addi x17, x17, 1
00209463 // bne taken
04052623 // wrong path store
00114463 // blt taken
04052623
00116463 // bltu not taken
00288893
00115463 // bge not taken
00488893
00117463 // bgeu taken
04052623
00C0096F // jal x18, +12
04052623
04052623
012888B3 // add x17, x17, x18
05152223
021909E7 // jalr x19, 0x21(x18)
04052623
04052623
04052623
05352423
00252A03 // lw x20, 2(x10) misaligned
@000000C0
00000200 0000005D 0000000F
00000204 0000006B 0000000F
00000208 00000001 0000000F
0000020C 00000000 0000000F
00000210 FFFFFF9D 0000000F
00000214 000000F0 0000000F
00000218 ABCDE000 0000000F
0000021C 00001048 0000000F
00000220 87654321 0000000F
00000224 10ECA864 0000000F
00000228 F8765432 0000000F
0000022C A8642000 0000000F
00000230 FFFFFFFF 0000000F
00000234 21212121 00000002
00000234 9D9D9D9D 00000008
00000238 E000E000 00000003
00000238 43214321 0000000C
0000023C 0000003A 0000000F
00000240 0000C000 0000000F
00000244 000000EB 0000000F
00000248 000000F8 0000000F
FFFFFFFF

//--- dv/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_core
	import rv_bus_pkg::*;
();

	localparam int MEM_WORDS = 256;
	localparam int TABLE_BASE = 192;
	localparam int STALL_LIMIT = 100;
	localparam int MAX_REQUESTS = 2000;
	localparam int QUIET_CYCLES = 20;

	logic                clk;
	logic                resetn;
	logic                mem_valid;
	mem_req_t            mem_req;
	logic                mem_ready;
	logic [`RV_XLEN-1:0] mem_rdata;
	logic                trap;

	logic [31:0] mem [0:MEM_WORDS-1];
	integer      seed;
	int          entry;
	logic [31:0] last_fetch;

	rv_core u_rv_core (
		.clk       (clk),
		.resetn    (resetn),
		.mem_valid (mem_valid),
		.mem_req   (mem_req),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata),
		.trap      (trap)
	);

	always #4 clk = ~clk;

	task automatic check_fetch(input string name, input logic [31:0] exp_addr,
	                           input mem_req_t act);
		if (act.addr !== exp_addr || act.wstrb !== 4'h0 || act.instr !== 1'b1) begin
			$write("CHECK FAILED %s expected addr %h wstrb 0 instr 1", name, exp_addr);
			$display(" actual addr %h wstrb %h instr %b", act.addr, act.wstrb, act.instr);
			$display("TESTS FAILED");
			$fatal(1, "fetch request mismatch");
		end
	endtask

	task automatic check_store(input string name, input mem_req_t exp, input mem_req_t act);
		if (act !== exp) begin
			$write("CHECK FAILED %s expected addr %h data %h strb %h instr %b",
			       name, exp.addr, exp.wdata, exp.wstrb, exp.instr);
			$display(" actual addr %h data %h strb %h instr %b",
			         act.addr, act.wdata, act.wstrb, act.instr);
			$display("TESTS FAILED");
			$fatal(1, "store request mismatch");
		end
	endtask

	task automatic check_trap(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected trap %b actual trap %b", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "trap level mismatch");
		end
	endtask

	// Returns at the first sampled request or trap
	task automatic wait_request(output logic saw_trap);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > STALL_LIMIT) begin
				$display("TESTS FAILED");
				$fatal(1, "neither a bus request nor a trap came within %0d cycles",
				       STALL_LIMIT);
			end
		end while (!mem_valid && !trap);
		saw_trap = trap && !mem_valid;
	endtask

	task automatic hold_check(input mem_req_t req);
		if (!mem_valid || mem_req !== req) begin
			$display("TESTS FAILED");
			$fatal(1, "bus request dropped or changed before completion");
		end
	endtask

	task automatic serve_request(input mem_req_t req);
		int       stall;
		int       idx;
		int       base;
		mem_req_t exp;
		stall = $random(seed) & 3;
		idx = int'(req.addr[9:2]);
		repeat (stall) begin
			@(negedge clk);
			hold_check(req);
		end
		@(posedge clk);
		mem_ready <= 1'b1;
		mem_rdata <= mem[idx];
		@(negedge clk);
		hold_check(req);
		if (req.instr)
			last_fetch = mem[idx];
		// Transfer completes on this edge
		@(posedge clk);
		mem_ready <= 1'b0;
		if (req.wstrb != 4'h0) begin
			base = TABLE_BASE + 3 * entry;
			if (mem[base] == 32'hffff_ffff) begin
				$display("TESTS FAILED");
				$fatal(1, "store to %h came after the last expected store", req.addr);
			end
			exp.addr = mem[base];
			exp.wdata = mem[base + 1];
			exp.wstrb = mem[base + 2][3:0];
			exp.instr = 1'b0;
			check_store($sformatf("store %0d", entry), exp, req);
			for (int b = 0; b < 4; b++) begin
				if (req.wstrb[b])
					mem[idx][8*b +: 8] = req.wdata[8*b +: 8];
			end
			entry++;
		end
		@(negedge clk);
		if (mem_valid) begin
			$display("TESTS FAILED");
			$fatal(1, "mem_valid stayed high in the cycle after the transfer");
		end
	endtask

	initial begin
		logic     saw_trap;
		int       requests;
		mem_req_t req;
		clk = 1'b0;
		resetn = 1'b0;
		mem_ready = 1'b0;
		mem_rdata = '0;
		seed = 32'he690_abcd;
		entry = 0;
		last_fetch = '0;
		saw_trap = 1'b0;
		requests = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = ~(i * 32'h0404_0405);
		$readmemh("dv/rv_core_stimulus.hex", mem);

		repeat (8) begin
			@(negedge clk);
			if (mem_valid !== 1'b0) begin
				$display("CHECK FAILED reset expected mem_valid 0 actual mem_valid %b",
				         mem_valid);
				$display("TESTS FAILED");
				$fatal(1, "bus request during reset");
			end
			check_trap("reset", 1'b0, trap);
		end
		@(posedge clk);
		resetn <= 1'b1;

		wait_request(saw_trap);
		if (saw_trap) begin
			$display("TESTS FAILED");
			$fatal(1, "trap raised before the first fetch");
		end
		req = mem_req;
		check_fetch("first fetch", `RV_RESET_PC, req);
		serve_request(req);
		requests = 1;

		while (!saw_trap) begin
			wait_request(saw_trap);
			if (!saw_trap) begin
				requests++;
				if (requests > MAX_REQUESTS) begin
					$display("TESTS FAILED");
					$fatal(1, "program did not reach the trap within %0d requests",
					       MAX_REQUESTS);
				end
				serve_request(mem_req);
			end
		end

		// The trap must come from the final load, with no bus access for it
		if (last_fetch[6:0] != 7'b0000011) begin
			$display("CHECK FAILED misaligned lw expected opcode 03 actual opcode %h",
			         last_fetch[6:0]);
			$display("TESTS FAILED");
			$fatal(1, "trap was not raised by the misaligned load");
		end
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			if (mem_valid) begin
				$display("TESTS FAILED");
				$fatal(1, "bus request after trap");
			end
			check_trap("trap held", 1'b1, trap);
		end

		if (mem[TABLE_BASE + 3 * entry] != 32'hffff_ffff) begin
			$display("TESTS FAILED");
			$fatal(1, "only %0d expected stores were seen before the trap", entry);
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

//--- rv_core.f
+incdir+source
source/rv_bus_pkg.sv
source/rv_isa_pkg.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_decode.sv
source/rv_mem_port.sv
source/rv_control.sv
source/rv_core.sv
dv/tb_rv_core.sv

//--- source/rv_alu.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_alu
	import rv_isa_pkg::*;
(
	input  logic [`RV_XLEN-1:0] a,
	input  logic [`RV_XLEN-1:0] b,
	input  shift_step_t         shift_step,
	input  alu_op_e             alu_op,
	output logic [`RV_XLEN-1:0] result,
	output logic                cond
);

	always_comb begin
		case (alu_op)
			ALU_BEQ:            cond = a == b;
			ALU_BNE:            cond = a != b;
			ALU_BLT, ALU_SLT:   cond = $signed(a) < $signed(b);
			ALU_BGE:            cond = $signed(a) >= $signed(b);
			ALU_BLTU, ALU_SLTU: cond = a < b;
			ALU_BGEU:           cond = a >= b;
			default:            cond = 1'b0;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_SUB:           result = a - b;
			ALU_SLT, ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, cond};
			ALU_XOR:           result = a ^ b;
			ALU_OR:            result = a | b;
			ALU_AND:           result = a & b;
			// One shift step per cycle while control counts down
			ALU_SLL:           result = a << shift_step;
			ALU_SRL:           result = a >> shift_step;
			ALU_SRA:           result = $signed(a) >>> shift_step;
			default:           result = a + b;
		endcase
	end

endmodule

//--- source/rv_bus_pkg.sv
`include "rv_cfg.svh"

package rv_bus_pkg;

	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_size_e;

	typedef enum logic [1:0] {
		MEM_FETCH,
		MEM_LOAD,
		MEM_STORE
	} mem_kind_e;

	// Request from the control FSM to the memory port
	typedef struct packed {
		mem_kind_e            kind;
		logic [`RV_XLEN-1:0]  addr;
		logic [`RV_XLEN-1:0]  wdata;
		mem_size_e            size;
		logic                 load_unsigned;
	} mem_cmd_t;

	// Native bus request, word aligned
	typedef struct packed {
		logic [`RV_XLEN-1:0]   addr;
		logic [`RV_XLEN-1:0]   wdata;
		logic [`RV_XLEN/8-1:0] wstrb;
		logic                  instr;
	} mem_req_t;

endpackage

//--- source/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural registers and index width
`define RV_NREGS 32
`define RV_REG_BITS 5

`define RV_RESET_PC 32'h0000_0000

// Bits moved per fast shift cycle
`define RV_SHIFT_STEP 4

`endif

//--- source/rv_control.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_control
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;
(
	input  logic                clk,
	input  logic                resetn,
	input  decoded_t            decoded,
	input  logic [`RV_XLEN-1:0] rs1_data,
	input  logic [`RV_XLEN-1:0] rs2_data,
	input  logic [`RV_XLEN-1:0] alu_result,
	input  logic                alu_cond,
	input  logic [`RV_XLEN-1:0] rd_data,
	input  logic                cmd_done,
	input  logic                misaligned,
	output logic [`RV_XLEN-1:0] op1,
	output logic [`RV_XLEN-1:0] op2,
	output shift_step_t         shift_amt_step,
	output alu_op_e             alu_op,
	output logic                wr_en,
	output reg_idx_t            wr_addr,
	output logic [`RV_XLEN-1:0] wr_data,
	output logic                decode_load,
	output logic                cmd_start,
	output mem_cmd_t            cmd,
	output logic                trap
);

	typedef enum logic [2:0] {
		S_FETCH, S_DECODE, S_EXEC, S_SHIFT, S_MEM, S_TRAP
	} state_e;

	state_e              state;
	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] pc_plus4;
	logic [`RV_XLEN-1:0] next_pc;
	logic [`RV_XLEN-1:0] out_q;
	reg_idx_t            shamt;
	logic                fetch_sent;
	logic                wb_pending;
	logic                is_mem;
	logic                is_shift;

	assign is_mem = decoded.cls == CLS_LOAD || decoded.cls == CLS_STORE;
	assign is_shift = decoded.cls == CLS_SHIFT_IMM || decoded.cls == CLS_SHIFT_REG;
	assign pc_plus4 = pc + `RV_XLEN'(4);
	assign alu_op = decoded.alu_op;
	assign shift_amt_step = (shamt >= `RV_SHIFT_STEP) ? shift_step_t'(`RV_SHIFT_STEP)
	                                                  : shift_step_t'(1);

	assign cmd_start = (state == S_FETCH && !fetch_sent) || (state == S_EXEC && is_mem);
	assign decode_load = state == S_FETCH && cmd_done;
	assign trap = state == S_TRAP;

	// Writeback lands in the first fetch cycle
	assign wr_en = state == S_FETCH && wb_pending;
	assign wr_addr = decoded.rd;
	assign wr_data = out_q;

	always_comb begin
		case (decoded.cls)
			CLS_JAL:    next_pc = alu_result;
			CLS_JALR:   next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
			CLS_BRANCH: next_pc = alu_cond ? pc + decoded.imm : pc_plus4;
			default:    next_pc = pc_plus4;
		endcase
	end

	always_comb begin
		cmd.kind = MEM_FETCH;
		cmd.addr = pc;
		cmd.wdata = rs2_data;
		cmd.size = MEM_WORD;
		cmd.load_unsigned = 1'b0;
		// Data access address comes straight from the adder
		if (state == S_EXEC) begin
			cmd.kind = (decoded.cls == CLS_STORE) ? MEM_STORE : MEM_LOAD;
			cmd.addr = alu_result;
			cmd.size = decoded.size;
			cmd.load_unsigned = decoded.load_unsigned;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= S_FETCH;
			pc <= `RV_RESET_PC;
			fetch_sent <= 1'b0;
			wb_pending <= 1'b0;
		end else begin
			case (state)
				S_FETCH: begin
					wb_pending <= 1'b0;
					if (cmd_start)
						fetch_sent <= 1'b1;
					if (misaligned) begin
						state <= S_TRAP;
					end else if (cmd_done) begin
						fetch_sent <= 1'b0;
						state <= S_DECODE;
					end
				end
				S_DECODE: begin
					if (decoded.illegal)
						state <= S_TRAP;
					else if (is_shift)
						state <= S_SHIFT;
					else
						state <= S_EXEC;
				end
				S_EXEC: begin
					pc <= next_pc;
					if (is_mem) begin
						state <= S_MEM;
					end else begin
						wb_pending <= decoded.cls != CLS_BRANCH;
						state <= S_FETCH;
					end
				end
				S_SHIFT: begin
					if (shamt == '0) begin
						pc <= pc_plus4;
						wb_pending <= 1'b1;
						state <= S_FETCH;
					end
				end
				S_MEM: begin
					if (misaligned) begin
						state <= S_TRAP;
					end else if (cmd_done) begin
						wb_pending <= decoded.cls == CLS_LOAD;
						state <= S_FETCH;
					end
				end
				default: state <= S_TRAP;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			S_DECODE: begin
				op1 <= (decoded.cls == CLS_AUIPC || decoded.cls == CLS_JAL) ? pc : rs1_data;
				op2 <= (decoded.cls == CLS_ALU_REG || decoded.cls == CLS_BRANCH) ? rs2_data
				                                                                 : decoded.imm;
				shamt <= (decoded.cls == CLS_SHIFT_REG) ? rs2_data[`RV_REG_BITS-1:0]
				                                        : decoded.rs2;
			end
			S_EXEC: begin
				case (decoded.cls)
					CLS_LUI:           out_q <= decoded.imm;
					CLS_JAL, CLS_JALR: out_q <= pc_plus4;
					default:           out_q <= alu_result;
				endcase
			end
			S_SHIFT: begin
				if (shamt != '0) begin
					op1 <= alu_result;
					shamt <= shamt - reg_idx_t'(shift_amt_step);
				end else begin
					out_q <= op1;
				end
			end
			S_MEM: begin
				if (cmd_done)
					out_q <= rd_data;
			end
			default: ;
		endcase
	end

endmodule

//--- source/rv_core.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;
(
	input  logic                clk,
	input  logic                resetn,
	output logic                mem_valid,
	output mem_req_t            mem_req,
	input  logic                mem_ready,
	input  logic [`RV_XLEN-1:0] mem_rdata,
	output logic                trap
);

	decoded_t            decoded;
	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic [`RV_XLEN-1:0] op1;
	logic [`RV_XLEN-1:0] op2;
	logic [`RV_XLEN-1:0] alu_result;
	logic                alu_cond;
	alu_op_e             alu_op;
	shift_step_t         shift_step;
	logic                wr_en;
	reg_idx_t            wr_addr;
	logic [`RV_XLEN-1:0] wr_data;
	logic                decode_load;
	logic                cmd_start;
	mem_cmd_t            cmd;
	logic                cmd_done;
	logic                misaligned;
	logic [`RV_XLEN-1:0] rd_data;

	rv_control u_rv_control (
		.clk            (clk),
		.resetn         (resetn),
		.decoded        (decoded),
		.rs1_data       (rs1_data),
		.rs2_data       (rs2_data),
		.alu_result     (alu_result),
		.alu_cond       (alu_cond),
		.rd_data        (rd_data),
		.cmd_done       (cmd_done),
		.misaligned     (misaligned),
		.op1            (op1),
		.op2            (op2),
		.shift_amt_step (shift_step),
		.alu_op         (alu_op),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.decode_load    (decode_load),
		.cmd_start      (cmd_start),
		.cmd            (cmd),
		.trap           (trap)
	);

	rv_decode u_rv_decode (
		.clk         (clk),
		.resetn      (resetn),
		.decode_load (decode_load),
		.instr       (rd_data),
		.decoded     (decoded)
	);

	rv_regfile u_rv_regfile (
		.clk      (clk),
		.rs1_addr (decoded.rs1),
		.rs2_addr (decoded.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	rv_alu u_rv_alu (
		.a          (op1),
		.b          (op2),
		.shift_step (shift_step),
		.alu_op     (alu_op),
		.result     (alu_result),
		.cond       (alu_cond)
	);

	rv_mem_port u_rv_mem_port (
		.clk        (clk),
		.resetn     (resetn),
		.cmd_start  (cmd_start),
		.cmd        (cmd),
		.cmd_done   (cmd_done),
		.rd_data    (rd_data),
		.misaligned (misaligned),
		.mem_valid  (mem_valid),
		.mem_req    (mem_req),
		.mem_ready  (mem_ready),
		.mem_rdata  (mem_rdata)
	);

endmodule

//--- source/rv_decode.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;
(
	input  logic                clk,
	input  logic                resetn,
	input  logic                decode_load,
	input  logic [`RV_XLEN-1:0] instr,
	output decoded_t            decoded
);

	instr_u     ir;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign funct3 = ir.r.funct3;
	assign funct7 = ir.r.funct7;

	// Shared by register-immediate and register-register forms
	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!resetn)
			ir <= '0;
		else if (decode_load)
			ir <= instr;
	end

	always_comb begin
		decoded = '0;
		decoded.rd = ir.r.rd;
		decoded.rs1 = ir.r.rs1;
		decoded.rs2 = ir.r.rs2;
		decoded.alu_op = ALU_ADD;
		decoded.size = mem_size_e'(funct3[1:0]);
		decoded.load_unsigned = funct3[2];
		decoded.imm = {{20{ir.i.imm[11]}}, ir.i.imm};
		case (ir.r.opcode)
			OP_LUI, OP_AUIPC: begin
				decoded.cls = (ir.u.opcode == OP_LUI) ? CLS_LUI : CLS_AUIPC;
				decoded.imm = {ir.u.imm, 12'b0};
			end
			OP_JAL: begin
				decoded.cls = CLS_JAL;
				decoded.imm = {{12{ir.j.imm20}}, ir.j.imm19_12, ir.j.imm11, ir.j.imm10_1, 1'b0};
			end
			OP_JALR: begin
				decoded.cls = CLS_JALR;
				decoded.illegal = funct3 != 3'b000;
			end
			OP_BRANCH: begin
				decoded.cls = CLS_BRANCH;
				decoded.imm = {{20{ir.b.imm12}}, ir.b.imm11, ir.b.imm10_5, ir.b.imm4_1, 1'b0};
				case (funct3)
					3'b000: decoded.alu_op = ALU_BEQ;
					3'b001: decoded.alu_op = ALU_BNE;
					3'b100: decoded.alu_op = ALU_BLT;
					3'b101: decoded.alu_op = ALU_BGE;
					3'b110: decoded.alu_op = ALU_BLTU;
					3'b111: decoded.alu_op = ALU_BGEU;
					default: decoded.illegal = 1'b1;
				endcase
			end
			OP_LOAD: begin
				decoded.cls = CLS_LOAD;
				// lw with the unsigned bit is an RV64 form
				decoded.illegal = funct3[1:0] == 2'b11 || funct3[2:1] == 2'b11;
			end
			OP_STORE: begin
				decoded.cls = CLS_STORE;
				decoded.imm = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
				decoded.illegal = funct3 > 3'b010;
			end
			OP_IMM: begin
				decoded.alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
				if (funct3 == 3'b001 || funct3 == 3'b101) begin
					decoded.cls = CLS_SHIFT_IMM;
					decoded.illegal = (funct7 & 7'b1011111) != 7'b0 ||
					                  (funct3 == 3'b001 && funct7[5]);
				end else begin
					decoded.cls = CLS_ALU_IMM;
				end
			end
			OP_REG: begin
				decoded.alu_op = arith_op(funct3, funct7[5]);
				decoded.cls = (funct3 == 3'b001 || funct3 == 3'b101) ? CLS_SHIFT_REG
				                                                     : CLS_ALU_REG;
				decoded.illegal = (funct7 & 7'b1011111) != 7'b0 ||
				                  (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101);
			end
			default: decoded.illegal = 1'b1;
		endcase
	end

endmodule

//--- source/rv_isa_pkg.sv
`include "rv_cfg.svh"

package rv_isa_pkg;
	import rv_bus_pkg::*;

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_OR, ALU_AND,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} alu_op_e;

	typedef enum logic [3:0] {
		CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH,
		CLS_LOAD, CLS_STORE, CLS_ALU_IMM, CLS_ALU_REG,
		CLS_SHIFT_IMM, CLS_SHIFT_REG
	} iclass_e;

	typedef logic [`RV_REG_BITS-1:0] reg_idx_t;
	typedef logic [$clog2(`RV_SHIFT_STEP + 1)-1:0] shift_step_t;

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		reg_idx_t    rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		reg_idx_t   rd;
		opcode_e    opcode;
	} j_fmt_t;

	// One instruction word, viewed per format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

	typedef struct packed {
		iclass_e             cls;
		alu_op_e             alu_op;
		reg_idx_t            rd;
		reg_idx_t            rs1;
		reg_idx_t            rs2;
		logic [`RV_XLEN-1:0] imm;
		mem_size_e           size;
		logic                load_unsigned;
		logic                illegal;
	} decoded_t;

endpackage

//--- source/rv_mem_port.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_mem_port
	import rv_bus_pkg::*;
(
	input  logic                clk,
	input  logic                resetn,
	input  logic                cmd_start,
	input  mem_cmd_t            cmd,
	output logic                cmd_done,
	output logic [`RV_XLEN-1:0] rd_data,
	output logic                misaligned,
	output logic                mem_valid,
	output mem_req_t            mem_req,
	input  logic                mem_ready,
	input  logic [`RV_XLEN-1:0] mem_rdata
);

	logic [`RV_XLEN-1:0]   wdata_placed;
	logic [`RV_XLEN/8-1:0] wstrb_placed;
	logic                  bad_align;
	logic [1:0]            lane_q;
	mem_size_e             size_q;
	logic                  unsigned_q;
	logic [`RV_XLEN-1:0]   lane_word;

	assign bad_align = (cmd.size == MEM_WORD && cmd.addr[1:0] != 2'b00) ||
	                   (cmd.size == MEM_HALF && cmd.addr[0]);
	assign cmd_done = mem_valid && mem_ready;

	// Replicate narrow stores across lanes
	always_comb begin
		case (cmd.size)
			MEM_BYTE: begin
				wdata_placed = {4{cmd.wdata[7:0]}};
				wstrb_placed = 4'b0001 << cmd.addr[1:0];
			end
			MEM_HALF: begin
				wdata_placed = {2{cmd.wdata[15:0]}};
				wstrb_placed = cmd.addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				wdata_placed = cmd.wdata;
				wstrb_placed = 4'b1111;
			end
		endcase
		if (cmd.kind != MEM_STORE)
			wstrb_placed = '0;
	end

	always_comb begin
		lane_word = mem_rdata >> {lane_q, 3'b000};
		case (size_q)
			MEM_BYTE: rd_data = {{24{lane_word[7] & !unsigned_q}}, lane_word[7:0]};
			MEM_HALF: rd_data = {{16{lane_word[15] & !unsigned_q}}, lane_word[15:0]};
			default:  rd_data = mem_rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			mem_valid <= 1'b0;
			misaligned <= 1'b0;
		end else begin
			misaligned <= cmd_start && bad_align;
			if (cmd_start && !bad_align)
				mem_valid <= 1'b1;
			else if (mem_ready)
				mem_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_start) begin
			mem_req.addr <= {cmd.addr[`RV_XLEN-1:2], 2'b00};
			mem_req.wdata <= wdata_placed;
			mem_req.wstrb <= wstrb_placed;
			mem_req.instr <= cmd.kind == MEM_FETCH;
			lane_q <= cmd.addr[1:0];
			size_q <= cmd.size;
			unsigned_q <= cmd.load_unsigned;
		end
	end

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regfile
	import rv_isa_pkg::*;
(
	input  logic                clk,
	input  reg_idx_t            rs1_addr,
	input  reg_idx_t            rs2_addr,
	output logic [`RV_XLEN-1:0] rs1_data,
	output logic [`RV_XLEN-1:0] rs2_data,
	input  logic                wr_en,
	input  reg_idx_t            wr_addr,
	input  logic [`RV_XLEN-1:0] wr_data
);

	// No storage behind x0
	logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

	always_ff @(posedge clk) begin
		if (wr_en && wr_addr != '0)
			regs[wr_addr] <= wr_data;
	end

endmodule
